//--- design/udp_rx_pkg.sv
package udp_rx_pkg;

  // --------------------
  // field types
  // --------------------

  // ethernet station address
  typedef logic [47:0] mac_addr_t;
  // ipv4 address
  typedef logic [31:0] ip_addr_t;
  // udp port number
  typedef logic [15:0] udp_port_t;
  // byte counts and length fields
  typedef logic [15:0] byte_len_t;

  // --------------------
  // header sizes in bytes
  // --------------------

  localparam int ETH_HDR_BYTES = 14;
  localparam int IP_HDR_BYTES = 20;
  localparam int UDP_HDR_BYTES = 8;
  // payload starts right after this
  localparam int TOTAL_HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

  // --------------------
  // protocol codes
  // --------------------

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  // udp in the ipv4 protocol field
  localparam logic [7:0] IP_PROTO_UDP = 8'd17;
  // upper nibble of the first ip byte
  localparam logic [3:0] IP_VERSION_4 = 4'd4;

endpackage

//--- design/axis_if.sv
interface axis_if #(
  parameter int DATA_WIDTH = 512
) ();

  // byte lane 0 holds the first wire byte
  logic [DATA_WIDTH-1:0]   tdata;
  logic [DATA_WIDTH/8-1:0] tkeep;
  logic                    tlast;
  logic                    tvalid;
  logic                    tready;

  // producer side
  modport source (
    output tdata, tkeep, tlast, tvalid,
    input  tready
  );

  // consumer side
  modport sink (
    input  tdata, tkeep, tlast, tvalid,
    output tready
  );

endinterface

//--- design/rx_stream_fifo.sv
module rx_stream_fifo #(
  parameter int DATA_WIDTH = 512,
  parameter int FIFO_DEPTH = 64
) (
  input logic    rx_axis_aclk,
  input logic    rx_axis_aresetn,
  axis_if.sink   wr,
  axis_if.source rd
);

  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  // storage, one entry per beat
  logic [DATA_WIDTH-1:0] data_mem [FIFO_DEPTH];
  logic [KEEP_WIDTH-1:0] keep_mem [FIFO_DEPTH];
  logic                  last_mem [FIFO_DEPTH];

  // extra msb tells full from empty
  logic [PTR_WIDTH:0] wr_ptr;
  logic [PTR_WIDTH:0] rd_ptr;
  logic               empty;
  logic               full;
  logic               do_write;
  logic               do_read;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]) &&
                (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]);

  assign do_write = wr.tvalid && wr.tready;
  assign do_read = rd.tvalid && rd.tready;

  assign wr.tready = !full;

  // head entry shows without a read cycle
  assign rd.tvalid = !empty;
  assign rd.tdata = data_mem[rd_ptr[PTR_WIDTH-1:0]];
  assign rd.tkeep = keep_mem[rd_ptr[PTR_WIDTH-1:0]];
  assign rd.tlast = last_mem[rd_ptr[PTR_WIDTH-1:0]];

  always_ff @(posedge rx_axis_aclk) begin
    if (do_write) begin
      data_mem[wr_ptr[PTR_WIDTH-1:0]] <= wr.tdata;
      keep_mem[wr_ptr[PTR_WIDTH-1:0]] <= wr.tkeep;
      last_mem[wr_ptr[PTR_WIDTH-1:0]] <= wr.tlast;
    end
  end

  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- design/rx_header_filter.sv
module rx_header_filter #(
  parameter int DATA_WIDTH = 512
) (
  input  logic                  rx_axis_aclk,
  input  logic                  rx_axis_aresetn,
  input  udp_rx_pkg::mac_addr_t cfg_dst_mac,
  input  udp_rx_pkg::mac_addr_t cfg_src_mac,
  input  udp_rx_pkg::ip_addr_t  cfg_dst_ip,
  input  udp_rx_pkg::udp_port_t cfg_dst_port,
  input  logic [DATA_WIDTH-1:0]   mac_rx_tdata,
  input  logic [DATA_WIDTH/8-1:0] mac_rx_tkeep,
  input  logic                  mac_rx_tlast,
  input  logic                  mac_rx_tvalid,
  output logic                  mac_rx_tready,
  axis_if.source                accepted,
  output logic                  first_accept,
  output udp_rx_pkg::byte_len_t expected_len
);

  import udp_rx_pkg::*;

  localparam int IP_OFS = ETH_HDR_BYTES;
  localparam int UDP_OFS = ETH_HDR_BYTES + IP_HDR_BYTES;

  // gathers len bytes from lane off upward, network order
  function automatic logic [47:0] field_be(input logic [DATA_WIDTH-1:0] data,
                                           input int off, input int len);
    logic [47:0] value;
    value = '0;
    for (int i = 0; i < len; i++) begin
      value = {value[39:0], data[8*(off+i) +: 8]};
    end
    return value;
  endfunction

  mac_addr_t   dst_mac;
  mac_addr_t   src_mac;
  logic [15:0] ether_type;
  logic [3:0]  ip_version;
  logic [7:0]  ip_proto;
  ip_addr_t    dst_ip;
  udp_port_t   dst_port;
  byte_len_t   udp_len;
  logic        hdr_match;
  logic        first_q;
  logic        accept_q;
  logic        accept_now;
  logic        mac_fire;

  // --------------------
  // header decode
  // --------------------
  assign dst_mac = mac_addr_t'(field_be(mac_rx_tdata, 0, 6));
  assign src_mac = mac_addr_t'(field_be(mac_rx_tdata, 6, 6));
  assign ether_type = 16'(field_be(mac_rx_tdata, 12, 2));
  // version in the high nibble of the ip byte 0
  assign ip_version = mac_rx_tdata[8*IP_OFS+4 +: 4];
  assign ip_proto = mac_rx_tdata[8*(IP_OFS+9) +: 8];
  assign dst_ip = ip_addr_t'(field_be(mac_rx_tdata, IP_OFS + 16, 4));
  assign dst_port = udp_port_t'(field_be(mac_rx_tdata, UDP_OFS + 2, 2));
  assign udp_len = byte_len_t'(field_be(mac_rx_tdata, UDP_OFS + 4, 2));

  // all 42 header bytes present and every field matches
  assign hdr_match = (&mac_rx_tkeep[TOTAL_HDR_BYTES-1:0]) &&
                     (dst_mac == cfg_dst_mac) && (src_mac == cfg_src_mac) &&
                     (ether_type == ETHERTYPE_IPV4) && (ip_version == IP_VERSION_4) &&
                     (ip_proto == IP_PROTO_UDP) && (dst_ip == cfg_dst_ip) &&
                     (dst_port == cfg_dst_port);

  // --------------------
  // frame gating
  // --------------------
  // live decision on the first beat, latched value afterwards
  assign accept_now = first_q ? hdr_match : accept_q;
  assign first_accept = first_q && hdr_match;
  assign expected_len = udp_len - byte_len_t'(UDP_HDR_BYTES);

  // rejected beats are swallowed here
  assign mac_rx_tready = accept_now ? accepted.tready : 1'b1;
  assign mac_fire = mac_rx_tvalid && mac_rx_tready;

  assign accepted.tvalid = mac_rx_tvalid && accept_now;
  assign accepted.tdata = mac_rx_tdata;
  assign accepted.tkeep = mac_rx_tkeep;
  assign accepted.tlast = mac_rx_tlast;

  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      first_q <= 1'b1;
      accept_q <= 1'b0;
    end else if (mac_fire) begin
      // next beat opens a frame after tlast
      first_q <= mac_rx_tlast;
      if (first_q) accept_q <= hdr_match;
    end
  end

endmodule

//--- design/rx_length_check.sv
module rx_length_check (
  input  logic                  rx_axis_aclk,
  input  logic                  rx_axis_aresetn,
  input  logic                  beat_fire,
  input  udp_rx_pkg::byte_len_t beat_keep_count,
  input  logic                  beat_last,
  input  logic                  first_accept,
  input  udp_rx_pkg::byte_len_t expected_len,
  output logic                  verdict_valid,
  output logic                  verdict_pass
);

  import udp_rx_pkg::*;

  // bytes seen in earlier beats of this frame
  byte_len_t   byte_count;
  byte_len_t   expected_q;
  byte_len_t   frame_total;
  byte_len_t   frame_expected;
  logic [16:0] wanted_total;
  logic        len_ok;

  // first beat restarts the count
  assign frame_total = (first_accept ? byte_len_t'(0) : byte_count) + beat_keep_count;
  // single-beat frames use the live value
  assign frame_expected = first_accept ? expected_len : expected_q;
  // one extra bit, a udp length below 8 never matches
  assign wanted_total = {1'b0, frame_expected} + 17'(TOTAL_HDR_BYTES);
  assign len_ok = ({1'b0, frame_total} == wanted_total);

  always_ff @(posedge rx_axis_aclk) begin
    if (beat_fire && first_accept) expected_q <= expected_len;
  end

  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      byte_count <= '0;
      verdict_valid <= 1'b0;
      verdict_pass <= 1'b0;
    end else begin
      // one verdict per accepted tlast
      verdict_valid <= beat_fire && beat_last;
      if (beat_fire) begin
        byte_count <= beat_last ? byte_len_t'(0) : frame_total;
        verdict_pass <= len_ok;
      end
    end
  end

endmodule

//--- design/rx_payload_extractor.sv
module rx_payload_extractor #(
  parameter int DATA_WIDTH = 512
) (
  input logic    rx_axis_aclk,
  input logic    rx_axis_aresetn,
  axis_if.sink   frame,
  axis_if.sink   verdict,
  axis_if.source payload
);

  import udp_rx_pkg::*;

  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  // payload bytes left in the first beat
  localparam int CARRY_BYTES = KEEP_WIDTH - TOTAL_HDR_BYTES;
  localparam int CARRY_BITS = CARRY_BYTES * 8;
  localparam int HDR_BITS = TOTAL_HDR_BYTES * 8;

  typedef enum logic [2:0] {
    wait_verdict,
    first_beat,
    stream,
    flush,
    discard
  } state_t;

  // byte enables widened to bit enables
  function automatic logic [DATA_WIDTH-1:0] keep_mask(input logic [KEEP_WIDTH-1:0] keep);
    logic [DATA_WIDTH-1:0] mask;
    for (int i = 0; i < KEEP_WIDTH; i++) begin
      mask[8*i +: 8] = {8{keep[i]}};
    end
    return mask;
  endfunction

  state_t                state;
  logic [DATA_WIDTH-1:0] carry_data;
  logic [KEEP_WIDTH-1:0] carry_keep;
  logic [KEEP_WIDTH-1:0] next_carry_keep;
  logic [DATA_WIDTH-1:0] joined_data;
  logic [KEEP_WIDTH-1:0] joined_keep;
  logic [KEEP_WIDTH-1:0] out_keep_next;
  logic [DATA_WIDTH-1:0] out_data_next;
  logic                  out_last_next;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_data;
  logic [KEEP_WIDTH-1:0] out_keep;
  logic                  out_last;
  logic                  load_ok;
  logic                  take_beat;
  logic                  load_out;

  // --------------------
  // realignment
  // --------------------
  // low bytes of this beat land above the carried bytes
  assign joined_data = (frame.tdata << CARRY_BITS) | carry_data;
  assign joined_keep = (frame.tkeep << CARRY_BYTES) | carry_keep;
  // upper part of this beat waits for the next one
  assign next_carry_keep = frame.tkeep >> TOTAL_HDR_BYTES;

  assign out_keep_next = (state == flush) ? carry_keep : joined_keep;
  assign out_data_next = ((state == flush) ? carry_data : joined_data) & keep_mask(out_keep_next);
  // last unless leftover bytes still need a flush beat
  assign out_last_next = (state == flush) || (frame.tlast && (next_carry_keep == '0));

  // --------------------
  // handshakes
  // --------------------
  // output register free or draining this cycle
  assign load_ok = !out_valid || payload.tready;

  always_comb begin
    case (state)
      first_beat: frame.tready = 1'b1;
      stream:     frame.tready = load_ok;
      discard:    frame.tready = 1'b1;
      default:    frame.tready = 1'b0;
    endcase
  end

  assign verdict.tready = (state == wait_verdict);
  assign take_beat = frame.tvalid && frame.tready;
  assign load_out = ((state == stream) && take_beat) || ((state == flush) && load_ok);

  assign payload.tvalid = out_valid;
  assign payload.tdata = out_data;
  assign payload.tkeep = out_keep;
  assign payload.tlast = out_last;

  always_ff @(posedge rx_axis_aclk) begin
    if (take_beat && ((state == first_beat) || (state == stream))) begin
      carry_data <= frame.tdata >> HDR_BITS;
      carry_keep <= next_carry_keep;
    end
    if (load_out) begin
      out_data <= out_data_next;
      out_keep <= out_keep_next;
      out_last <= out_last_next;
    end
  end

  // --------------------
  // frame sequencing
  // --------------------
  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      state <= wait_verdict;
      out_valid <= 1'b0;
    end else begin
      // taken beats leave unless refilled below
      if (payload.tready) out_valid <= 1'b0;
      if (load_out) out_valid <= 1'b1;
      case (state)
        wait_verdict: begin
          // pass bit sits in lane 0
          if (verdict.tvalid) state <= verdict.tdata[0] ? first_beat : discard;
        end
        first_beat, stream: begin
          if (take_beat && frame.tlast) begin
            state <= (next_carry_keep != '0) ? flush : wait_verdict;
          end else if (take_beat) begin
            state <= stream;
          end
        end
        flush: begin
          if (load_ok) state <= wait_verdict;
        end
        discard: begin
          // failed frame drained without output
          if (take_beat && frame.tlast) state <= wait_verdict;
        end
        default: state <= wait_verdict;
      endcase
    end
  end

endmodule

//--- design/udp_rx_top.sv
module udp_rx_top #(
  parameter int DATA_WIDTH = 512,
  parameter int FIFO_DEPTH = 64
) (
  input  logic                    rx_axis_aclk,
  input  logic                    rx_axis_aresetn,
  input  udp_rx_pkg::mac_addr_t   cfg_dst_mac,
  input  udp_rx_pkg::mac_addr_t   cfg_src_mac,
  input  udp_rx_pkg::ip_addr_t    cfg_dst_ip,
  input  udp_rx_pkg::udp_port_t   cfg_dst_port,
  input  logic [DATA_WIDTH-1:0]   mac_rx_tdata,
  input  logic [DATA_WIDTH/8-1:0] mac_rx_tkeep,
  input  logic                    mac_rx_tlast,
  input  logic                    mac_rx_tvalid,
  output logic                    mac_rx_tready,
  output logic [DATA_WIDTH-1:0]   udp_rx_tdata,
  output logic [DATA_WIDTH/8-1:0] udp_rx_tkeep,
  output logic                    udp_rx_tlast,
  output logic                    udp_rx_tvalid,
  input  logic                    udp_rx_tready
);

  import udp_rx_pkg::*;

  axis_if #(.DATA_WIDTH(DATA_WIDTH)) accepted_if ();
  axis_if #(.DATA_WIDTH(DATA_WIDTH)) frame_if ();
  axis_if #(.DATA_WIDTH(DATA_WIDTH)) payload_if ();
  // verdict queue, one byte wide
  axis_if #(.DATA_WIDTH(8)) verdict_in_if ();
  axis_if #(.DATA_WIDTH(8)) verdict_out_if ();

  logic      first_accept;
  byte_len_t expected_len;
  byte_len_t beat_keep_count;
  logic      beat_fire;
  logic      verdict_valid;
  logic      verdict_pass;

  // --------------------
  // header match and gating
  // --------------------
  rx_header_filter #(.DATA_WIDTH(DATA_WIDTH)) u_filter (
    .rx_axis_aclk, .rx_axis_aresetn,
    .cfg_dst_mac, .cfg_src_mac, .cfg_dst_ip, .cfg_dst_port,
    .mac_rx_tdata, .mac_rx_tkeep, .mac_rx_tlast, .mac_rx_tvalid, .mac_rx_tready,
    .accepted(accepted_if.source),
    .first_accept, .expected_len
  );

  // length check sees only accepted beats
  assign beat_fire = accepted_if.tvalid && accepted_if.tready;
  assign beat_keep_count = byte_len_t'($countones(accepted_if.tkeep));

  rx_length_check u_length_check (
    .rx_axis_aclk, .rx_axis_aresetn,
    .beat_fire, .beat_keep_count, .beat_last(accepted_if.tlast),
    .first_accept, .expected_len,
    .verdict_valid, .verdict_pass
  );

  assign verdict_in_if.tdata = {7'b0, verdict_pass};
  assign verdict_in_if.tkeep = 1'b1;
  assign verdict_in_if.tlast = 1'b1;
  assign verdict_in_if.tvalid = verdict_valid;

  // --------------------
  // storage
  // --------------------
  rx_stream_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_payload_fifo (
    .rx_axis_aclk, .rx_axis_aresetn,
    .wr(accepted_if.sink), .rd(frame_if.source)
  );

  // same depth so a verdict always finds room
  rx_stream_fifo #(.DATA_WIDTH(8), .FIFO_DEPTH(FIFO_DEPTH)) u_verdict_fifo (
    .rx_axis_aclk, .rx_axis_aresetn,
    .wr(verdict_in_if.sink), .rd(verdict_out_if.source)
  );

  rx_payload_extractor #(.DATA_WIDTH(DATA_WIDTH)) u_extractor (
    .rx_axis_aclk, .rx_axis_aresetn,
    .frame(frame_if.sink), .verdict(verdict_out_if.sink), .payload(payload_if.source)
  );

  // user stream
  assign udp_rx_tdata = payload_if.tdata;
  assign udp_rx_tkeep = payload_if.tkeep;
  assign udp_rx_tlast = payload_if.tlast;
  assign udp_rx_tvalid = payload_if.tvalid;
  assign payload_if.tready = udp_rx_tready;

endmodule

//--- verif/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int CLK_PERIOD = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic rx_axis_aclk,
  output logic rx_axis_aresetn
);

  timeunit 1ns;
  timeprecision 1ps;

  // free running clock
  initial begin
    rx_axis_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) rx_axis_aclk = ~rx_axis_aclk;
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    rx_axis_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge rx_axis_aclk);
    @(negedge rx_axis_aclk);
    rx_axis_aresetn = 1'b1;
  end

endmodule

//--- verif/udp_rx_tb.sv
module udp_rx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH = 512;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  localparam int FIFO_DEPTH = 64;
  localparam int CLK_PERIOD = 100;
  // watchdog allowance per golden line
  localparam int CYCLES_PER_LINE = 40;
  localparam int DRAIN_CYCLES = 200;
  localparam int IDLE_CYCLES = 20;
  localparam GOLDEN_FILE = "verif/udp_rx_golden.mem";

  typedef struct packed {
    logic                  last;
    logic [KEEP_WIDTH-1:0] keep;
    logic [DATA_WIDTH-1:0] data;
  } beat_t;

  logic                  rx_axis_aclk;
  logic                  rx_axis_aresetn;
  logic [47:0]           cfg_dst_mac;
  logic [47:0]           cfg_src_mac;
  logic [31:0]           cfg_dst_ip;
  logic [15:0]           cfg_dst_port;
  logic [DATA_WIDTH-1:0] mac_rx_tdata;
  logic [KEEP_WIDTH-1:0] mac_rx_tkeep;
  logic                  mac_rx_tlast;
  logic                  mac_rx_tvalid;
  logic                  mac_rx_tready;
  logic [DATA_WIDTH-1:0] udp_rx_tdata;
  logic [KEEP_WIDTH-1:0] udp_rx_tkeep;
  logic                  udp_rx_tlast;
  logic                  udp_rx_tvalid;
  logic                  udp_rx_tready;

  // beats from the golden file
  beat_t in_q[$];
  beat_t exp_q[$];
  int    golden_lines;
  logic  golden_loaded;
  logic [31:0] lfsr_state;

  tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clock_gen (
    .rx_axis_aclk, .rx_axis_aresetn
  );

  udp_rx_top #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
    .rx_axis_aclk, .rx_axis_aresetn,
    .cfg_dst_mac, .cfg_src_mac, .cfg_dst_ip, .cfg_dst_port,
    .mac_rx_tdata, .mac_rx_tkeep, .mac_rx_tlast, .mac_rx_tvalid, .mac_rx_tready,
    .udp_rx_tdata, .udp_rx_tkeep, .udp_rx_tlast, .udp_rx_tvalid, .udp_rx_tready
  );

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // taps x^32 + x^22 + x^2 + x + 1 stepped one bit per call
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // C line holds the config and I and O lines hold beats
  // other lines are skipped
  task automatic load_golden();
    int                    fd;
    int                    n;
    string                 line;
    logic [7:0]            tag;
    logic                  f_last;
    logic [KEEP_WIDTH-1:0] f_keep;
    logic [DATA_WIDTH-1:0] f_data;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run("could not open the golden data file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line[0] == "C") begin
          n = $sscanf(line, "%c %h %h %h %h", tag, cfg_dst_mac, cfg_src_mac,
                      cfg_dst_ip, cfg_dst_port);
          if (n != 5) begin
            abort_run("configuration line in the golden file is malformed");
          end else begin
            golden_lines++;
          end
        end else if (line[0] == "I" || line[0] == "O") begin
          n = $sscanf(line, "%c %h %h %h", tag, f_last, f_keep, f_data);
          if (n != 4) begin
            abort_run("beat line in the golden file is malformed");
          end else begin
            if (tag == "I") in_q.push_back({f_last, f_keep, f_data});
            else exp_q.push_back({f_last, f_keep, f_data});
            golden_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // MAC side driver and end of run
  // --------------------
  initial begin : drive_input
    logic fired;
    int   drain;
    mac_rx_tdata = '0;
    mac_rx_tkeep = '0;
    mac_rx_tlast = 1'b0;
    mac_rx_tvalid = 1'b0;
    cfg_dst_mac = '0;
    cfg_src_mac = '0;
    cfg_dst_ip = '0;
    cfg_dst_port = '0;
    golden_lines = 0;
    golden_loaded = 1'b0;
    load_golden();
    golden_loaded = 1'b1;
    $display("golden file: %0d input beats, %0d expected beats", in_q.size(), exp_q.size());
    wait (rx_axis_aresetn === 1'b1);
    // idle after reset with both FIFOs empty
    #(CLK_PERIOD / 4);
    check_value("idle mac_rx_tready", 1'b1, mac_rx_tready);
    check_value("idle udp_rx_tvalid", 1'b0, udp_rx_tvalid);
    @(negedge rx_axis_aclk);
    foreach (in_q[i]) begin
      mac_rx_tdata = in_q[i].data;
      mac_rx_tkeep = in_q[i].keep;
      mac_rx_tlast = in_q[i].last;
      mac_rx_tvalid = 1'b1;
      // hold the beat until tready is seen ahead of a rising edge
      do begin
        #(CLK_PERIOD / 4);
        fired = mac_rx_tready;
        @(negedge rx_axis_aclk);
      end while (!fired);
    end
    mac_rx_tvalid = 1'b0;
    mac_rx_tlast = 1'b0;
    drain = 0;
    while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
      @(negedge rx_axis_aclk);
      drain++;
    end
    // window for a stray extra beat
    repeat (IDLE_CYCLES) @(negedge rx_axis_aclk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected output beats never appeared", exp_q.size()));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // --------------------
  // user side back-pressure and checker
  // --------------------
  initial begin : collect_output
    beat_t exp_beat;
    int    out_idx;
    udp_rx_tready = 1'b0;
    lfsr_state = 32'hd573a800;
    out_idx = 0;
    wait (rx_axis_aresetn === 1'b1);
    forever begin
      @(negedge rx_axis_aclk);
      lfsr_state = lfsr_step(lfsr_state);
      udp_rx_tready = lfsr_state[0];
      // outputs settled before the rising edge that completes this handshake
      #(CLK_PERIOD / 4);
      if (udp_rx_tvalid === 1'b1 && udp_rx_tready) begin
        if (exp_q.size() == 0) begin
          abort_run("the DUT sent an output beat that no expected beat accounts for");
        end else begin
          exp_beat = exp_q.pop_front();
          check_value($sformatf("output beat %0d tlast", out_idx), exp_beat.last, udp_rx_tlast);
          check_value($sformatf("output beat %0d tkeep", out_idx), exp_beat.keep, udp_rx_tkeep);
          check_value($sformatf("output beat %0d tdata", out_idx), exp_beat.data, udp_rx_tdata);
          out_idx++;
        end
      end
    end
  end

  // run length scales with the golden file
  initial begin : watchdog
    wait (golden_loaded === 1'b1);
    repeat (golden_lines * CYCLES_PER_LINE) @(posedge rx_axis_aclk);
    abort_run("the watchdog expired before all frames were processed");
  end

endmodule

//--- udp_rx.f
design/udp_rx_pkg.sv
design/axis_if.sv
design/rx_stream_fifo.sv
design/rx_header_filter.sv
design/rx_length_check.sv
design/rx_payload_extractor.sv
design/udp_rx_top.sv
verif/tb_clock_gen.sv
verif/udp_rx_tb.sv

//--- Bender.yml
package:
  name: udp_rx

sources:
  # synthesizable receive path, package first
  - files:
      - design/udp_rx_pkg.sv
      - design/axis_if.sv
      - design/rx_stream_fifo.sv
      - design/rx_header_filter.sv
      - design/rx_length_check.sv
      - design/rx_payload_extractor.sv
      - design/udp_rx_top.sv
  # simulation only
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/udp_rx_tb.sv

//--- verif/udp_rx_golden.mem
// C dst_mac src_mac dst_ip dst_port
// I or O, then last, keep (hex, 64 lanes), data (hex, lane 0 rightmost)
C 021122334455 0266778899aa 0a000002 1234
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a0000114000400000260000450008aa9988776602554433221102
O 1 00000000000003ff 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000a9a8a7a6a5a4a3a2a1a0
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a0000114000400000260000450008aa9988776602554433221103
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a0000114000400000260000450008ab9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a000011400040000026000045dd86aa9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a0000114000400000260000650008aa9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100200000a0100000a0000064000400000260000450008aa9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200341200100300000a0100000a0000114000400000260000450008aa9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000a9a8a7a6a5a4a3a2a1a000001200351200100200000a0100000a0000114000400000260000450008aa9988776602554433221102
I 1 000fffffffffffff 000000000000000000000000c9c8c7c6c5c4c3c2c1c000001400341200100200000a0100000a0000114000400000260000450008aa9988776602554433221102
I 0 ffffffffffffffff 9594939291908f8e8d8c8b8a8988878685848382818000005000341200100200000a0100000a0000114000400000640000450008aa9988776602554433221102
I 1 0003ffffffffffff 0000000000000000000000000000c7c6c5c4c3c2c1c0bfbebdbcbbbab9b8b7b6b5b4b3b2b1b0afaeadacabaaa9a8a7a6a5a4a3a2a1a09f9e9d9c9b9a99989796
O 0 ffffffffffffffff bfbebdbcbbbab9b8b7b6b5b4b3b2b1b0afaeadacabaaa9a8a7a6a5a4a3a2a1a09f9e9d9c9b9a999897969594939291908f8e8d8c8b8a89888786858483828180
O 1 00000000000000ff 0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000c7c6c5c4c3c2c1c0
I 1 000fffffffffffff 000000000000000000000000b9b8b7b6b5b4b3b2b1b000001200341200100200000a0100000a0000114000400000260000450008aa9988776602554433221102
O 1 00000000000003ff 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000b9b8b7b6b5b4b3b2b1b0
